// File: flist.f
+incdir+include
hw/cpu_pkg.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/id_ex_buffer.sv
hw/alu_stage.sv
hw/ex_wb_buffer.sv
hw/pipeline_top.sv
tests/tb_pipeline.sv

// File: hw/alu_stage.sv
/* Execute stage ALU with immediate selection, result also feeds
   the younger forward path */
`timescale 1ns/1ps
`default_nettype none

module alu_stage
   import cpu_pkg::*;
#(
   parameter int DATA_W = cpu_pkg::DATA_W
) (
   input  wire  ex_ctrl_t ex_ctrl,
   input  wire  data_t    r_data_0,
   input  wire  data_t    r_data_1,
   input  wire  imm_t     imm,
   output data_t          result
);

   logic [DATA_W-1:0] imm_sext;
   logic [DATA_W-1:0] imm_upper;
   logic [DATA_W-1:0] op_b;     // second operand after imm select

   assign imm_sext  = {{(DATA_W-16){imm[15]}}, imm};
   assign imm_upper = {imm, {(DATA_W-16){1'b0}}};

   always_comb begin
      case (ex_ctrl)
         ADDI:    op_b = imm_sext;
         LUI:     op_b = imm_upper;
         default: op_b = r_data_1;
      endcase
   end

   always_comb begin
      case (ex_ctrl)
         ADD, ADDI: result = r_data_0 + op_b;
         SUB:       result = r_data_0 - op_b;
         AND:       result = r_data_0 & op_b;
         OR:        result = r_data_0 | op_b;
         XOR:       result = r_data_0 ^ op_b;
         LUI:       result = op_b;
         SLT: begin
            result = {{(DATA_W-1){1'b0}}, ($signed(r_data_0) < $signed(op_b))};
         end
         default:   result = '0;  // nop and unassigned codes
      endcase
   end

endmodule

`default_nettype wire

// File: hw/cpu_pkg.sv
/* Shared package: default widths, word and register typedefs,
   opcode enum, control field types and instruction field positions */
`default_nettype none

package cpu_pkg;

   localparam int DATA_W   = 32;  // default word width
   localparam int NUM_REGS = 16;  // default register count

   typedef logic [DATA_W-1:0]           data_t;
   typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
   typedef logic [15:0]                 imm_t;

   // codes 9..15 are not assigned and behave as NOP
   typedef enum logic [3:0] {
      NOP  = 4'd0,
      ADD  = 4'd1,
      SUB  = 4'd2,
      AND  = 4'd3,
      OR   = 4'd4,
      XOR  = 4'd5,
      ADDI = 4'd6,  // rs0 + sign-extended imm
      LUI  = 4'd7,  // imm into upper half
      SLT  = 4'd8   // signed compare, 1 or 0
   } opcode_e;

   typedef logic [3:0] ex_ctrl_t;  // alu operation, same codes as opcode_e
   typedef logic       wb_ctrl_t;  // register write enable

   // instruction word layout, msb of each field
   // opcode, rd, rs0 and rs1 are 4 bits wide, imm takes the low 16
   localparam int OP_MSB  = 31;
   localparam int RD_MSB  = 27;
   localparam int RS0_MSB = 23;
   localparam int RS1_MSB = 19;
   localparam int IMM_MSB = 15;

endpackage

`default_nettype wire

// File: hw/decode_stage.sv
/* Decode stage: field split, execute and writeback control,
   operand selection from the two forward sources and the register file */
`timescale 1ns/1ps
`default_nettype none

module decode_stage
   import cpu_pkg::*;
#(
   parameter int DATA_W = cpu_pkg::DATA_W
) (
   input  wire  data_t    instr,
   input  wire            instr_valid,
   output reg_idx_t       rf_addr_0,
   output reg_idx_t       rf_addr_1,
   input  wire  data_t    rf_data_0,
   input  wire  data_t    rf_data_1,
   input  wire  wb_ctrl_t ex_wr_en,   // younger source, id/ex buffer
   input  wire  reg_idx_t ex_rd,
   input  wire  data_t    ex_result,
   input  wire  wb_ctrl_t wb_wr_en,   // older source, ex/wb buffer
   input  wire  reg_idx_t wb_rd,
   input  wire  data_t    wb_data,
   output ex_ctrl_t       ex_ctrl,
   output wb_ctrl_t       wb_ctrl,
   output reg_idx_t       rd,
   output imm_t           imm,
   output data_t          r_data_0,
   output data_t          r_data_1
);

   opcode_e op;
   logic    known;  // one of the assigned operations

   assign op        = opcode_e'(instr[OP_MSB -: 4]);
   assign rd        = instr[RD_MSB -: 4];
   assign rf_addr_0 = instr[RS0_MSB -: 4];
   assign rf_addr_1 = instr[RS1_MSB -: 4];
   assign imm       = instr[IMM_MSB:0];

   always_comb begin
      case (op)
         ADD, SUB, AND, OR, XOR, ADDI, LUI, SLT: known = 1'b1;
         default:                                known = 1'b0;
      endcase
   end

   // invalid input or unknown code becomes a bubble
   assign ex_ctrl = (instr_valid && known) ? ex_ctrl_t'(op) : ex_ctrl_t'(NOP);
   assign wb_ctrl = instr_valid && known && (rd != '0);

   // youngest producer wins, r0 is always zero
   function automatic logic [DATA_W-1:0] pick_operand(
      input reg_idx_t          src,
      input logic [DATA_W-1:0] rf_val
   );
      if (src == '0) begin
         return '0;
      end
      if (ex_wr_en && (ex_rd == src)) begin
         return ex_result;
      end
      if (wb_wr_en && (wb_rd == src)) begin
         return wb_data;
      end
      return rf_val;
   endfunction

   always_comb begin
      r_data_0 = pick_operand(rf_addr_0, rf_data_0);
      r_data_1 = pick_operand(rf_addr_1, rf_data_1);
   end

endmodule

`default_nettype wire

// File: hw/ex_wb_buffer.sv
/* Execute/writeback stage register, drives the writeback port,
   the register file write and the older forward source */
`timescale 1ns/1ps
`default_nettype none

module ex_wb_buffer
   import cpu_pkg::*;
(
   input  wire            clk,
   input  wire            rst,
   input  wire            stall,
   input  wire  wb_ctrl_t wb_ctrl,
   input  wire  reg_idx_t rd,
   input  wire  data_t    result,
   output logic           out_valid,
   output reg_idx_t       out_rd,
   output data_t          out_data
);

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         out_valid <= 1'b0;
      end else if (!stall) begin
         out_valid <= wb_ctrl;
      end
   end

   // held while stalled, so the port stays stable until accepted
   always_ff @(posedge clk) begin
      if (!stall) begin
         out_rd   <= rd;
         out_data <= result;
      end
   end

endmodule

`default_nettype wire

// File: hw/id_ex_buffer.sv
/* Decode/execute stage register, holds under stall,
   resets to a no-write bubble */
`timescale 1ns/1ps
`default_nettype none

module id_ex_buffer
   import cpu_pkg::*;
(
   input  wire            clk,
   input  wire            rst,
   input  wire            stall,
   input  wire  ex_ctrl_t ex_ctrl,
   input  wire  wb_ctrl_t wb_ctrl,
   input  wire  reg_idx_t rd,
   input  wire  imm_t     imm,
   input  wire  data_t    r_data_0,
   input  wire  data_t    r_data_1,
   output ex_ctrl_t       ex_ctrl_saved,
   output wb_ctrl_t       wb_ctrl_saved,  // also the younger forward enable
   output reg_idx_t       rd_saved,       // also the younger forward tag
   output imm_t           imm_saved,
   output data_t          r_data_0_out,
   output data_t          r_data_1_out
);

   // control fields
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         ex_ctrl_saved <= ex_ctrl_t'(NOP);
         wb_ctrl_saved <= 1'b0;  // no write
      end else if (!stall) begin
         ex_ctrl_saved <= ex_ctrl;
         wb_ctrl_saved <= wb_ctrl;
      end
   end

   // payload only matters when wb_ctrl_saved is set
   always_ff @(posedge clk) begin
      if (!stall) begin
         rd_saved     <= rd;
         imm_saved    <= imm;
         r_data_0_out <= r_data_0;
         r_data_1_out <= r_data_1;
      end
   end

endmodule

`default_nettype wire

// File: hw/pipeline_top.sv
/* Pipeline top level: register file, decode, id/ex buffer, alu,
   ex/wb buffer, global stall and input ready */
`timescale 1ns/1ps
`default_nettype none

module pipeline_top
   import cpu_pkg::*;
#(
   parameter int DATA_W   = cpu_pkg::DATA_W,
   parameter int NUM_REGS = cpu_pkg::NUM_REGS
) (
   input  wire            clk,
   input  wire            rst,
   input  wire            in_valid,
   output logic           in_ready,
   input  wire  data_t    in_instr,
   output logic           out_valid,
   input  wire            out_ready,
   output reg_idx_t       out_rd,
   output data_t          out_data
);

   logic     stall;
   logic     wb_fire;
   reg_idx_t rf_addr_0, rf_addr_1;
   data_t    rf_data_0, rf_data_1;

   ex_ctrl_t dec_ex_ctrl;
   wb_ctrl_t dec_wb_ctrl;
   reg_idx_t dec_rd;
   imm_t     dec_imm;
   data_t    dec_data_0, dec_data_1;

   ex_ctrl_t ex_ctrl;
   wb_ctrl_t ex_wr_en;
   reg_idx_t ex_rd;
   imm_t     ex_imm;
   data_t    ex_data_0, ex_data_1;
   data_t    alu_result;

   assign stall    = out_valid & ~out_ready;  // result held at the port
   assign in_ready = ~stall;
   assign wb_fire  = out_valid & out_ready;

   reg_file #(.NUM_REGS(NUM_REGS), .DATA_W(DATA_W)) u_rf (
      .clk(clk), .rst(rst),
      .rd_addr_0(rf_addr_0), .rd_addr_1(rf_addr_1),
      .rd_data_0(rf_data_0), .rd_data_1(rf_data_1),
      .wr_en(wb_fire), .wr_addr(out_rd), .wr_data(out_data)
   );

   decode_stage #(.DATA_W(DATA_W)) u_dec (
      .instr(in_instr), .instr_valid(in_valid & in_ready),
      .rf_addr_0(rf_addr_0), .rf_addr_1(rf_addr_1),
      .rf_data_0(rf_data_0), .rf_data_1(rf_data_1),
      .ex_wr_en(ex_wr_en), .ex_rd(ex_rd), .ex_result(alu_result),
      .wb_wr_en(out_valid), .wb_rd(out_rd), .wb_data(out_data),
      .ex_ctrl(dec_ex_ctrl), .wb_ctrl(dec_wb_ctrl), .rd(dec_rd), .imm(dec_imm),
      .r_data_0(dec_data_0), .r_data_1(dec_data_1)
   );

   id_ex_buffer u_id_ex (
      .clk(clk), .rst(rst), .stall(stall),
      .ex_ctrl(dec_ex_ctrl), .wb_ctrl(dec_wb_ctrl), .rd(dec_rd), .imm(dec_imm),
      .r_data_0(dec_data_0), .r_data_1(dec_data_1),
      .ex_ctrl_saved(ex_ctrl), .wb_ctrl_saved(ex_wr_en), .rd_saved(ex_rd),
      .imm_saved(ex_imm), .r_data_0_out(ex_data_0), .r_data_1_out(ex_data_1)
   );

   alu_stage #(.DATA_W(DATA_W)) u_alu (
      .ex_ctrl(ex_ctrl), .r_data_0(ex_data_0), .r_data_1(ex_data_1),
      .imm(ex_imm), .result(alu_result)
   );

   ex_wb_buffer u_ex_wb (
      .clk(clk), .rst(rst), .stall(stall),
      .wb_ctrl(ex_wr_en), .rd(ex_rd), .result(alu_result),
      .out_valid(out_valid), .out_rd(out_rd), .out_data(out_data)
   );

endmodule

`default_nettype wire

// File: hw/reg_file.sv
/* Register file with two combinational read ports and one write port,
   register 0 reads as zero */
`timescale 1ns/1ps
`default_nettype none

module reg_file
   import cpu_pkg::*;
#(
   parameter int NUM_REGS = cpu_pkg::NUM_REGS,
   parameter int DATA_W   = cpu_pkg::DATA_W
) (
   input  wire            clk,
   input  wire            rst,
   input  wire  reg_idx_t rd_addr_0,
   input  wire  reg_idx_t rd_addr_1,
   output data_t          rd_data_0,
   output data_t          rd_data_1,
   input  wire            wr_en,
   input  wire  reg_idx_t wr_addr,
   input  wire  data_t    wr_data
);

   logic [DATA_W-1:0] regs [NUM_REGS];

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && (wr_addr != '0)) begin  // r0 never written
         regs[wr_addr] <= wr_data;
      end
   end

   // no internal bypass, the forward paths in decode cover it
   assign rd_data_0 = (rd_addr_0 == '0) ? '0 : regs[rd_addr_0];
   assign rd_data_1 = (rd_addr_1 == '0) ? '0 : regs[rd_addr_1];

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# compile and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_pipeline -f flist.f -o tb_pipeline_sim

sim_out=$(./obj_dir/tb_pipeline_sim)
echo "$sim_out"

if echo "$sim_out" | grep -qF "=== PASS ==="; then
   exit 0
else
   exit 1
fi

// File: include/isa_ref.svh
/* Reference function for the testbench, executes one instruction
   on a model register array */
`ifndef ISA_REF_SVH
`define ISA_REF_SVH

// wr is set only for an assigned operation with rd != 0
function automatic void isa_ref_exec(
   input  cpu_pkg::data_t    instr,
   inout  cpu_pkg::data_t    regs [cpu_pkg::NUM_REGS],
   output logic              wr,
   output cpu_pkg::reg_idx_t rd,
   output cpu_pkg::data_t    value
);
   cpu_pkg::opcode_e  op;
   cpu_pkg::reg_idx_t rs0;
   cpu_pkg::reg_idx_t rs1;
   cpu_pkg::imm_t     imm;
   cpu_pkg::data_t    a;
   cpu_pkg::data_t    b;
   cpu_pkg::data_t    sx;

   op  = cpu_pkg::opcode_e'(instr[cpu_pkg::OP_MSB -: 4]);
   rd  = instr[cpu_pkg::RD_MSB -: 4];
   rs0 = instr[cpu_pkg::RS0_MSB -: 4];
   rs1 = instr[cpu_pkg::RS1_MSB -: 4];
   imm = instr[cpu_pkg::IMM_MSB:0];
   a   = (rs0 == '0) ? '0 : regs[rs0];
   b   = (rs1 == '0) ? '0 : regs[rs1];
   sx  = {{16{imm[15]}}, imm};
   wr  = 1'b1;

   case (op)
      cpu_pkg::ADD:  value = a + b;
      cpu_pkg::SUB:  value = a - b;
      cpu_pkg::AND:  value = a & b;
      cpu_pkg::OR:   value = a | b;
      cpu_pkg::XOR:  value = a ^ b;
      cpu_pkg::ADDI: value = a + sx;
      cpu_pkg::LUI:  value = {imm, 16'h0000};
      cpu_pkg::SLT:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: begin
         value = '0;
         wr    = 1'b0;  // nop or unassigned code
      end
   endcase

   if (rd == '0) begin
      wr = 1'b0;  // r0 writes are dropped
   end
   if (wr) begin
      regs[rd] = value;
   end
endfunction

`endif

// File: tests/tb_pipeline.sv
/* Pipeline testbench with directed and random programs, back-pressure,
   a scoreboard against the reference function and a timeout */
`timescale 1ns/1ps
`default_nettype none

module tb_pipeline
   import cpu_pkg::*;
();

   localparam int N_DIRECTED  = 29;
   localparam int N_RANDOM    = 300;
   localparam int MAX_CYCLES  = 4 * (N_DIRECTED + N_RANDOM) + 200;
   localparam int DRAIN_LIMIT = 50;  // cycles to wait for outstanding results

   logic     clk;
   logic     rst;
   logic     in_valid;
   logic     in_ready;
   data_t    in_instr;
   logic     out_valid;
   logic     out_ready;
   reg_idx_t out_rd;
   data_t    out_data;

   int          cycle      = 0;
   int          n_mismatch = 0;
   int          n_other    = 0;
   logic        bp_mode    = 1'b0;  // random out_ready when set
   logic        timed_mode = 1'b0;  // latency checked on accept
   logic [31:0] gen_state  = 32'd33826;
   logic [31:0] bp_state   = 32'd33826 ^ 32'h5a5a5a5a;

   data_t    model_regs [NUM_REGS];
   reg_idx_t exp_rd_q    [$];
   data_t    exp_data_q  [$];
   int       exp_cycle_q [$];
   logic     exp_timed_q [$];
   data_t    prog        [$];

   `include "isa_ref.svh"

   pipeline_top #(.DATA_W(DATA_W), .NUM_REGS(NUM_REGS)) DUT (
      .clk(clk), .rst(rst),
      .in_valid(in_valid), .in_ready(in_ready), .in_instr(in_instr),
      .out_valid(out_valid), .out_ready(out_ready),
      .out_rd(out_rd), .out_data(out_data)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) cycle <= cycle + 1;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic data_t encode_instr(input opcode_e op, input reg_idx_t rd,
                                          input reg_idx_t rs0, input reg_idx_t rs1,
                                          input imm_t imm);
      return {op, rd, rs0, rs1, imm};
   endfunction

   task automatic report_mismatch(input string sig, input data_t exp, input data_t act);
      n_mismatch++;
      $display("MISMATCH t=%0t %s expected 0x%08h got 0x%08h", $time, sig, exp, act);
   endtask

   task automatic report_error(input string msg);
      n_other++;
      $display("ERROR t=%0t %s", $time, msg);
   endtask

   // holds in_instr until an edge with in_ready and returns 1 ns after it
   task automatic send_instr(input data_t instr);
      logic taken;
      in_valid = 1'b1;
      in_instr = instr;
      taken    = 1'b0;
      while (!taken) begin
         @(posedge clk);
         taken = in_ready;
         #1;
      end
      in_valid = 1'b0;
   endtask

   task automatic send_prog();
      foreach (prog[i]) send_instr(prog[i]);
      prog.delete();
   endtask

   // waits a bounded time for the expected queue to empty
   task automatic drain();
      int waited;
      waited = 0;
      while (exp_rd_q.size() != 0 && waited < DRAIN_LIMIT) begin
         @(posedge clk);
         #1;
         waited++;
      end
      assert (exp_rd_q.size() == 0) else report_error("expected results never appeared");
      repeat (3) @(posedge clk);
      #1;
   endtask

   // out_ready stays high unless back-pressure is on
   initial begin : ready_driver
      logic mode;
      out_ready = 1'b1;
      forever begin
         @(posedge clk);
         mode = bp_mode;
         #1;
         bp_state  = lcg_next(bp_state);
         out_ready = mode ? (bp_state[31:30] != 2'b00) : 1'b1;
      end
   end

   always @(posedge clk) begin : scoreboard
      logic     held;
      reg_idx_t held_rd;
      data_t    held_data;
      logic     wr;
      reg_idx_t ref_rd;
      data_t    ref_val;
      if (!rst) begin
         held = 1'b0;
      end else begin
         // a held result must stay put
         if (held) begin
            assert (out_valid) else report_error("out_valid dropped before acceptance");
            assert (out_rd == held_rd) else report_mismatch("out_rd", held_rd, out_rd);
            assert (out_data == held_data) else report_mismatch("out_data", held_data, out_data);
         end
         assert (!(out_valid && !out_ready && in_ready))
            else report_error("in_ready high while the output is held");
         held      = out_valid && !out_ready;
         held_rd   = out_rd;
         held_data = out_data;

         if (out_valid && out_ready) begin
            assert (exp_rd_q.size() != 0) else report_error("writeback with no result expected");
            if (exp_rd_q.size() != 0) begin
               assert (out_rd == exp_rd_q[0]) else report_mismatch("out_rd", exp_rd_q[0], out_rd);
               assert (out_data == exp_data_q[0])
                  else report_mismatch("out_data", exp_data_q[0], out_data);
               if (exp_timed_q[0]) begin
                  assert (cycle - exp_cycle_q[0] == 2)
                     else report_mismatch("latency", 2, cycle - exp_cycle_q[0]);
               end
               void'(exp_rd_q.pop_front());
               void'(exp_data_q.pop_front());
               void'(exp_cycle_q.pop_front());
               void'(exp_timed_q.pop_front());
            end
         end

         if (in_valid && in_ready) begin
            isa_ref_exec(in_instr, model_regs, wr, ref_rd, ref_val);
            if (wr) begin
               exp_rd_q.push_back(ref_rd);
               exp_data_q.push_back(ref_val);
               exp_cycle_q.push_back(cycle);
               exp_timed_q.push_back(timed_mode);
            end
         end
      end
   end

   initial begin : stimulus
      logic [31:0] hi_word;
      in_valid = 1'b0;
      in_instr = '0;
      rst      = 1'b0;
      for (int r = 0; r < NUM_REGS; r++) model_regs[r] = '0;
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b1;
      assert (!out_valid) else report_error("out_valid high after reset");
      assert (in_ready) else report_error("in_ready low after reset");
      repeat (5) @(posedge clk);  // nothing may come out while idle
      #1;

      timed_mode = 1'b1;
      // every operation with negative immediates and signed compares
      prog.push_back(encode_instr(ADDI, 1, 0, 0, 16'h1234));
      prog.push_back(encode_instr(ADDI, 2, 0, 0, 16'hfffb));
      prog.push_back(encode_instr(LUI,  3, 0, 0, 16'h8000));
      prog.push_back(encode_instr(ADDI, 4, 0, 0, 16'd100));
      prog.push_back(encode_instr(ADD,  5, 1, 4, 16'h0));
      prog.push_back(encode_instr(SUB,  6, 2, 4, 16'h0));
      prog.push_back(encode_instr(AND,  7, 5, 1, 16'h0));
      prog.push_back(encode_instr(OR,   8, 3, 1, 16'h0));
      prog.push_back(encode_instr(XOR,  9, 8, 2, 16'h0));
      prog.push_back(encode_instr(SLT, 10, 3, 4, 16'h0));
      prog.push_back(encode_instr(SLT, 11, 4, 2, 16'h0));
      prog.push_back(encode_instr(SLT, 12, 2, 4, 16'h0));
      prog.push_back(encode_instr(ADDI, 13, 4, 0, 16'hff9c));
      send_prog();
      drain();

      // dependent chain where each reads the last two results
      prog.push_back(encode_instr(ADDI, 1, 0, 0, 16'd7));
      prog.push_back(encode_instr(ADDI, 2, 1, 0, 16'd3));
      prog.push_back(encode_instr(ADD,  3, 2, 1, 16'h0));
      prog.push_back(encode_instr(SUB,  4, 3, 2, 16'h0));
      prog.push_back(encode_instr(XOR,  5, 4, 3, 16'h0));
      prog.push_back(encode_instr(ADD,  1, 5, 4, 16'h0));
      prog.push_back(encode_instr(SLT,  6, 4, 1, 16'h0));
      prog.push_back(encode_instr(OR,   7, 6, 1, 16'h0));
      send_prog();
      drain();

      // no-write cases and then r0 read back
      prog.push_back(encode_instr(NOP,  3, 1, 2, 16'h0));
      prog.push_back({4'hc, 4'd4, 4'd1, 4'd2, 16'h0});
      prog.push_back({4'hf, 4'd5, 4'd1, 4'd2, 16'h0});
      prog.push_back(encode_instr(ADDI, 0, 1, 0, 16'd55));
      prog.push_back(encode_instr(ADD,  0, 1, 2, 16'h0));
      prog.push_back(encode_instr(ADD,  7, 0, 0, 16'h0));
      prog.push_back(encode_instr(ADDI, 8, 0, 0, 16'd9));
      prog.push_back(encode_instr(OR,   9, 0, 8, 16'h0));
      send_prog();
      drain();

      // random program under back-pressure and with input gaps
      timed_mode = 1'b0;
      bp_mode    = 1'b1;
      for (int i = 0; i < N_RANDOM; i++) begin
         gen_state = lcg_next(gen_state);
         if (gen_state[31:30] == 2'b00) begin
            @(posedge clk);
            #1;
         end
         gen_state = lcg_next(gen_state);
         hi_word   = gen_state;
         gen_state = lcg_next(gen_state);
         send_instr({hi_word[31:16], gen_state[31:16]});
      end
      bp_mode = 1'b0;
      drain();

      $display("errors %0d: %0d mismatches, %0d other", n_mismatch + n_other, n_mismatch,
               n_other);
      if (n_mismatch == 0 && n_other == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   initial begin : watchdog
      while (cycle < MAX_CYCLES) @(posedge clk);
      report_error("timeout, results still outstanding");
      $display("errors %0d: %0d mismatches, %0d other", n_mismatch + n_other, n_mismatch,
               n_other);
      $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire
